// ==== hw/monitor_cmd_pkg.sv ====
`default_nettype none

package monitor_cmd_pkg;

    typedef logic [15:0] reg_addr_t;
    typedef logic [15:0] reg_data_t;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } cmd_op_t;

    // Target block of a command; other codes are unknown groups
    typedef enum logic [6:0] {
        GRP_CTRL    = 7'h20,
        GRP_STATUS  = 7'h21,
        GRP_MON_REG = 7'h22
    } cmd_group_t;

    // Host command word, also the layout of read messages
    typedef struct packed {
        cmd_op_t    op;
        cmd_group_t group;
        reg_addr_t  addr;
        reg_data_t  data;
    } cmd_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_WAIT,
        ST_REPLY
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== hw/agc_sig_pkg.sv ====
`default_nettype none

package agc_sig_pkg;

    typedef logic [15:0] agc_word_t;

    // Write gates for the central registers
    typedef struct packed {
        logic mwag;
        logic mwlg;
        logic mwqg;
        logic mwzg;
        logic mwbg;
        logic mwg;
    } write_gates_t;

    // All alarm lines are active low
    typedef struct packed {
        logic mvfail_n;
        logic moscal_n;
        logic mscafl_n;
        logic mscdbl_n;
        logic mctral_n;
        logic mtcal_n;
        logic mrptal_n;
        logic mpal_n;
        logic mwatch_n;
        logic mpipal_n;
        logic mwarnf_n;
    } alarms_t;

    typedef struct packed {
        logic mnhrpt;
        logic mnhnc;
        logic nhalga;
        logic nhstrt1;
        logic nhstrt2;
        logic doscal;
        logic dbltst;
    } inhibits_t;

    // Alarm is mpal_n low, gojam is mgojam high, inst is mnisq high
    typedef struct packed {
        logic on_alarm;
        logic on_gojam;
        logic on_inst;
    } stop_conds_t;

endpackage

`default_nettype wire

// ==== hw/cmd_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module cmd_controller (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      cmd_valid,
    input  monitor_cmd_pkg::cmd_t     cmd,
    output logic                      cmd_ready,
    input  monitor_cmd_pkg::reg_data_t read_data,
    output logic                      read_msg_valid,
    output monitor_cmd_pkg::cmd_t     read_msg,
    output monitor_cmd_pkg::reg_addr_t blk_addr,
    output monitor_cmd_pkg::reg_data_t blk_data,
    output logic                      ctrl_read_en,
    output logic                      ctrl_write_en,
    output logic                      status_read_en,
    output logic                      status_write_en,
    output logic                      mon_reg_read_en,
    output logic                      mon_reg_write_en
);

    monitor_cmd_pkg::ctrl_state_t state;
    monitor_cmd_pkg::cmd_t        cmd_q;
    monitor_cmd_pkg::reg_data_t   rdata_q;
    logic                         is_write;

    assign cmd_ready = (state == monitor_cmd_pkg::ST_IDLE);
    assign is_write  = (cmd_q.op == monitor_cmd_pkg::OP_WRITE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= monitor_cmd_pkg::ST_IDLE;
        end else begin
            case (state)
                monitor_cmd_pkg::ST_IDLE: begin
                    if (cmd_valid) begin
                        state <= monitor_cmd_pkg::ST_ISSUE;
                    end
                end
                monitor_cmd_pkg::ST_ISSUE: state <= monitor_cmd_pkg::ST_WAIT;
                monitor_cmd_pkg::ST_WAIT:  state <= monitor_cmd_pkg::ST_REPLY;
                default:                   state <= monitor_cmd_pkg::ST_IDLE;
            endcase
        end
    end

    // Command is held for the whole transaction
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cmd_q   <= '0;
            rdata_q <= '0;
        end else begin
            if (cmd_ready && cmd_valid) begin
                cmd_q <= cmd;
            end
            // Block data_out is valid in the cycle after the strobe
            if (state == monitor_cmd_pkg::ST_WAIT) begin
                rdata_q <= read_data;
            end
        end
    end

    assign blk_addr = cmd_q.addr;
    assign blk_data = cmd_q.data;

    // One strobe per command; unknown groups strobe nothing
    always_comb begin
        ctrl_read_en     = 1'b0;
        ctrl_write_en    = 1'b0;
        status_read_en   = 1'b0;
        status_write_en  = 1'b0;
        mon_reg_read_en  = 1'b0;
        mon_reg_write_en = 1'b0;
        if (state == monitor_cmd_pkg::ST_ISSUE) begin
            case (cmd_q.group)
                monitor_cmd_pkg::GRP_CTRL: begin
                    ctrl_write_en = is_write;
                    ctrl_read_en  = !is_write;
                end
                monitor_cmd_pkg::GRP_STATUS: begin
                    status_write_en = is_write;
                    status_read_en  = !is_write;
                end
                monitor_cmd_pkg::GRP_MON_REG: begin
                    mon_reg_write_en = is_write;
                    mon_reg_read_en  = !is_write;
                end
                default: ;
            endcase
        end
    end

    // Reply echoes the request header with the collected data
    assign read_msg_valid = (state == monitor_cmd_pkg::ST_REPLY) && !is_write;
    assign read_msg = '{
        op:    cmd_q.op,
        group: cmd_q.group,
        addr:  cmd_q.addr,
        data:  rdata_q
    };

    a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({ctrl_read_en, ctrl_write_en, status_read_en,
                  status_write_en, mon_reg_read_en, mon_reg_write_en}));

endmodule

`default_nettype wire

// ==== hw/control_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_regs (
    input  logic                       clk,
    input  logic                       rst_n,
    input  monitor_cmd_pkg::reg_addr_t addr,
    input  monitor_cmd_pkg::reg_data_t data_in,
    input  logic                       read_en,
    input  logic                       write_en,
    output monitor_cmd_pkg::reg_data_t data_out,
    output agc_sig_pkg::stop_conds_t   stop_conds,
    output logic                       start_req,
    output logic                       proceed_req,
    input  agc_sig_pkg::stop_conds_t   stop_cause,
    output agc_sig_pkg::inhibits_t     inhibits
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stop_conds  <= '0;
            inhibits    <= '0;
            start_req   <= 1'b0;
            proceed_req <= 1'b0;
            data_out    <= '0;
        end else begin
            if (write_en && addr == 16'd0) begin
                stop_conds <= agc_sig_pkg::stop_conds_t'(data_in[2:0]);
            end
            if (write_en && addr == 16'd1) begin
                inhibits <= agc_sig_pkg::inhibits_t'(data_in[6:0]);
            end
            // Request pulses last one cycle
            start_req   <= write_en && (addr == 16'd2);
            proceed_req <= write_en && (addr == 16'd3);

            data_out <= '0;
            if (read_en) begin
                case (addr)
                    16'd0:   data_out <= {13'b0, stop_conds};
                    16'd1:   data_out <= {9'b0, inhibits};
                    16'd4:   data_out <= {13'b0, stop_cause};
                    default: data_out <= '0;
                endcase
            end
        end
    end

    a_req_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(start_req && proceed_req));

endmodule

`default_nettype wire

// ==== hw/start_stop.sv ====
`timescale 1ns/1ps
`default_nettype none

module start_stop #(
    parameter int START_PULSE_CYCLES = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  agc_sig_pkg::stop_conds_t stop_conds,
    input  logic                     start_req,
    input  logic                     proceed_req,
    input  logic                     mgojam,
    input  logic                     mnisq,
    input  logic                     mpal_n,
    output agc_sig_pkg::stop_conds_t stop_cause,
    output logic                     mstrt,
    output logic                     mstp
);

    localparam int CNT_W = $clog2(START_PULSE_CYCLES + 1);

    logic [2:0]       cond_now;
    logic [2:0]       hit;
    logic             stop_latch;
    logic [CNT_W-1:0] strt_cnt;

    // Same bit order as stop_conds_t
    assign cond_now = {!mpal_n, mgojam, mnisq};
    assign hit      = stop_conds & cond_now;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stop_latch <= 1'b0;
            stop_cause <= '0;
        end else if (proceed_req) begin
            // Proceed beats a stop event in the same cycle
            stop_latch <= 1'b0;
            stop_cause <= '0;
        end else if (|hit) begin
            stop_latch <= 1'b1;
            stop_cause <= stop_cause | hit;
        end
    end

    // Down-counter times the start pulse
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            strt_cnt <= '0;
        end else if (start_req) begin
            strt_cnt <= CNT_W'(START_PULSE_CYCLES);
        end else if (strt_cnt != '0) begin
            strt_cnt <= strt_cnt - CNT_W'(1);
        end
    end

    assign mstrt = (strt_cnt != '0);
    assign mstp  = stop_latch;

    a_stop_has_cause: assert property (@(posedge clk) disable iff (!rst_n)
        mstp |-> (stop_cause != '0));

endmodule

`default_nettype wire

// ==== hw/status_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module status_regs #(
    parameter int ALARM_SYNC_STAGES = 2
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  monitor_cmd_pkg::reg_addr_t addr,
    input  monitor_cmd_pkg::reg_data_t data_in,
    input  logic                       read_en,
    input  logic                       write_en,
    output monitor_cmd_pkg::reg_data_t data_out,
    input  agc_sig_pkg::alarms_t       alarms
);

    logic [ALARM_SYNC_STAGES-1:0][10:0] sync_q;
    logic [10:0]                        active;
    logic [10:0]                        latched;
    logic [10:0]                        clr;

    // Last stage is the synchronized copy; active alarms read as 1
    assign active = ~sync_q[ALARM_SYNC_STAGES-1];
    assign clr    = (write_en && addr == 16'd0) ? data_in[10:0] : 11'b0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync_q   <= '1;
            latched  <= '0;
            data_out <= '0;
        end else begin
            sync_q  <= {sync_q[ALARM_SYNC_STAGES-2:0], alarms};
            // A still-active alarm sets again over a clear
            latched <= (latched & ~clr) | active;

            data_out <= '0;
            if (read_en) begin
                case (addr)
                    16'd0:   data_out <= {5'b0, latched};
                    16'd1:   data_out <= {5'b0, active};
                    default: data_out <= '0;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/monitor_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module monitor_regs (
    input  logic                       clk,
    input  logic                       rst_n,
    input  monitor_cmd_pkg::reg_addr_t addr,
    input  logic                       read_en,
    output monitor_cmd_pkg::reg_data_t data_out,
    input  logic                       monwt,
    input  agc_sig_pkg::agc_word_t     mwl,
    input  agc_sig_pkg::write_gates_t  gates
);

    localparam int NUM_REGS = 6;

    // Index order is A, L, Q, Z, B, G
    agc_sig_pkg::agc_word_t regs_q [NUM_REGS];
    logic                   monwt_q;
    logic                   monwt_rise;
    logic [NUM_REGS-1:0]    gate_vec;

    assign monwt_rise = monwt && !monwt_q;
    assign gate_vec   = gates;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            monwt_q <= 1'b0;
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else begin
            monwt_q <= monwt;
            if (monwt_rise) begin
                // Gate bits run from mwag at the top down to mwg
                for (int i = 0; i < NUM_REGS; i++) begin
                    if (gate_vec[NUM_REGS-1-i]) begin
                        regs_q[i] <= mwl;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_out <= '0;
        end else if (read_en && addr < 16'd6) begin
            data_out <= regs_q[addr[2:0]];
        end else begin
            data_out <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== hw/monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module monitor #(
    parameter int START_PULSE_CYCLES = 4,
    parameter int ALARM_SYNC_STAGES  = 2
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      cmd_valid,
    input  monitor_cmd_pkg::cmd_t     cmd,
    output logic                      cmd_ready,
    output logic                      read_msg_valid,
    output monitor_cmd_pkg::cmd_t     read_msg,
    input  logic                      monwt,
    input  agc_sig_pkg::agc_word_t    mwl,
    input  agc_sig_pkg::write_gates_t gates,
    input  logic                      mgojam,
    input  logic                      mnisq,
    input  agc_sig_pkg::alarms_t      alarms,
    output logic                      mstrt,
    output logic                      mstp,
    output agc_sig_pkg::inhibits_t    inhibits
);

    monitor_cmd_pkg::reg_addr_t blk_addr;
    monitor_cmd_pkg::reg_data_t blk_data;
    monitor_cmd_pkg::reg_data_t read_data;
    monitor_cmd_pkg::reg_data_t ctrl_data;
    monitor_cmd_pkg::reg_data_t status_data;
    monitor_cmd_pkg::reg_data_t mon_reg_data;

    logic ctrl_read_en;
    logic ctrl_write_en;
    logic status_read_en;
    logic status_write_en;
    logic mon_reg_read_en;
    logic start_req;
    logic proceed_req;

    agc_sig_pkg::stop_conds_t stop_conds;
    agc_sig_pkg::stop_conds_t stop_cause;

    // Idle blocks drive zero, so OR-ing selects the active one
    assign read_data = ctrl_data | status_data | mon_reg_data;

    cmd_controller u_cmd_ctrl (
        .clk              (clk),
        .rst_n            (rst_n),
        .cmd_valid        (cmd_valid),
        .cmd              (cmd),
        .cmd_ready        (cmd_ready),
        .read_data        (read_data),
        .read_msg_valid   (read_msg_valid),
        .read_msg         (read_msg),
        .blk_addr         (blk_addr),
        .blk_data         (blk_data),
        .ctrl_read_en     (ctrl_read_en),
        .ctrl_write_en    (ctrl_write_en),
        .status_read_en   (status_read_en),
        .status_write_en  (status_write_en),
        .mon_reg_read_en  (mon_reg_read_en),
        .mon_reg_write_en ()
    );

    control_regs u_ctrl_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .addr        (blk_addr),
        .data_in     (blk_data),
        .read_en     (ctrl_read_en),
        .write_en    (ctrl_write_en),
        .data_out    (ctrl_data),
        .stop_conds  (stop_conds),
        .start_req   (start_req),
        .proceed_req (proceed_req),
        .stop_cause  (stop_cause),
        .inhibits    (inhibits)
    );

    start_stop #(
        .START_PULSE_CYCLES (START_PULSE_CYCLES)
    ) u_start_stop (
        .clk         (clk),
        .rst_n       (rst_n),
        .stop_conds  (stop_conds),
        .start_req   (start_req),
        .proceed_req (proceed_req),
        .mgojam      (mgojam),
        .mnisq       (mnisq),
        .mpal_n      (alarms.mpal_n),
        .stop_cause  (stop_cause),
        .mstrt       (mstrt),
        .mstp        (mstp)
    );

    status_regs #(
        .ALARM_SYNC_STAGES (ALARM_SYNC_STAGES)
    ) u_status_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .addr     (blk_addr),
        .data_in  (blk_data),
        .read_en  (status_read_en),
        .write_en (status_write_en),
        .data_out (status_data),
        .alarms   (alarms)
    );

    monitor_regs u_mon_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .addr     (blk_addr),
        .read_en  (mon_reg_read_en),
        .data_out (mon_reg_data),
        .monwt    (monwt),
        .mwl      (mwl),
        .gates    (gates)
    );

endmodule

`default_nettype wire

// ==== bench/monitor_tb_checks.svh ====
`ifndef MONITOR_TB_CHECKS_SVH
`define MONITOR_TB_CHECKS_SVH

task automatic check_msg(monitor_cmd_pkg::cmd_t got, monitor_cmd_pkg::cmd_t exp);
    check_count++;
    if (got !== exp) begin
        err_count++;
        $display("ERROR read_msg got %h exp %h", got, exp);
    end
endtask

task automatic check_inhibits(agc_sig_pkg::inhibits_t got, agc_sig_pkg::inhibits_t exp);
    check_count++;
    if (got !== exp) begin
        err_count++;
        $display("ERROR inhibits got %h exp %h", got, exp);
    end
endtask

task automatic check_width(string name, int got, int exp);
    check_count++;
    if (got != exp) begin
        err_count++;
        $display("ERROR %s got %h exp %h", name, got, exp);
    end
endtask

task automatic check_level(string name, logic got, logic exp);
    check_count++;
    if (got !== exp) begin
        err_count++;
        $display("ERROR %s got %h exp %h", name, got, exp);
    end
endtask

// Leaves the caller 1 ns past a rising edge
task automatic step_cycles(int n);
    repeat (n) @(posedge clk);
    #1;
endtask

// Sends one command and returns once the controller is idle again
task automatic issue_cmd(monitor_cmd_pkg::cmd_t c);
    int busy;
    int valid_at;
    busy = 0;
    valid_at = 0;
    while (!cmd_ready) step_cycles(1);
    cmd = c;
    cmd_valid = 1'b1;
    step_cycles(1);
    cmd_valid = 1'b0;
    while (!cmd_ready) begin
        busy++;
        if (read_msg_valid) begin
            valid_at = busy;
        end
        step_cycles(1);
    end
    // Busy for three cycles, reply in the third
    check_width("cmd_ready low cycles", busy, 3);
    check_width("read_msg_valid cycle", valid_at,
                (c.op == monitor_cmd_pkg::OP_READ) ? 3 : 0);
endtask

task automatic read_reg(logic [6:0] grp, logic [15:0] addr);
    monitor_cmd_pkg::cmd_t c;
    c = '{op: monitor_cmd_pkg::OP_READ, group: monitor_cmd_pkg::cmd_group_t'(grp),
          addr: addr, data: 16'h0000};
    exp_q.push_back(expected_msg(c));
    issue_cmd(c);
endtask

task automatic write_reg(logic [6:0] grp, logic [15:0] addr, logic [15:0] data);
    monitor_cmd_pkg::cmd_t c;
    c = '{op: monitor_cmd_pkg::OP_WRITE, group: monitor_cmd_pkg::cmd_group_t'(grp),
          addr: addr, data: data};
    model_write(c);
    issue_cmd(c);
endtask

`endif

// ==== bench/monitor_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module monitor_tb;

    localparam int START_PULSE_CYCLES = 4;
    localparam int ALARM_SYNC_STAGES  = 2;
    localparam int MAX_CYCLES         = 4000;

    logic                      clk;
    logic                      rst_n;
    logic                      cmd_valid;
    monitor_cmd_pkg::cmd_t     cmd;
    logic                      cmd_ready;
    logic                      read_msg_valid;
    monitor_cmd_pkg::cmd_t     read_msg;
    logic                      monwt;
    agc_sig_pkg::agc_word_t    mwl;
    agc_sig_pkg::write_gates_t gates;
    logic                      mgojam;
    logic                      mnisq;
    agc_sig_pkg::alarms_t      alarms;
    logic                      mstrt;
    logic                      mstp;
    agc_sig_pkg::inhibits_t    inhibits;

    // Reference model state
    agc_sig_pkg::stop_conds_t  m_stop_conds;
    agc_sig_pkg::stop_conds_t  m_stop_cause;
    agc_sig_pkg::inhibits_t    m_inhibits;
    logic [10:0]               m_latched;
    agc_sig_pkg::agc_word_t    m_regs [6];

    monitor_cmd_pkg::cmd_t     exp_q [$];
    int                        err_count;
    int                        check_count;
    int                        cycle_count;
    int                        mstrt_run;
    int                        mstrt_width;
    int                        mstrt_pulses;

    monitor #(
        .START_PULSE_CYCLES (START_PULSE_CYCLES),
        .ALARM_SYNC_STAGES  (ALARM_SYNC_STAGES)
    ) i_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .cmd_valid      (cmd_valid),
        .cmd            (cmd),
        .cmd_ready      (cmd_ready),
        .read_msg_valid (read_msg_valid),
        .read_msg       (read_msg),
        .monwt          (monwt),
        .mwl            (mwl),
        .gates          (gates),
        .mgojam         (mgojam),
        .mnisq          (mnisq),
        .alarms         (alarms),
        .mstrt          (mstrt),
        .mstp           (mstp),
        .inhibits       (inhibits)
    );

    always #4 clk = ~clk;

    // Expected read message for a command, from the model state
    function automatic monitor_cmd_pkg::cmd_t expected_msg(monitor_cmd_pkg::cmd_t c);
        monitor_cmd_pkg::cmd_t m;
        m = c;
        m.data = 16'h0000;
        case (c.group)
            monitor_cmd_pkg::GRP_CTRL: begin
                case (c.addr)
                    16'd0:   m.data = {13'b0, m_stop_conds};
                    16'd1:   m.data = {9'b0, m_inhibits};
                    16'd4:   m.data = {13'b0, m_stop_cause};
                    default: m.data = 16'h0000;
                endcase
            end
            monitor_cmd_pkg::GRP_STATUS: begin
                // Live alarms are always released when the bench reads
                if (c.addr == 16'd0) begin
                    m.data = {5'b0, m_latched};
                end
            end
            monitor_cmd_pkg::GRP_MON_REG: begin
                if (c.addr < 16'd6) begin
                    m.data = m_regs[c.addr[2:0]];
                end
            end
            default: m.data = 16'h0000;
        endcase
        return m;
    endfunction

    function automatic void model_write(monitor_cmd_pkg::cmd_t c);
        if (c.group == monitor_cmd_pkg::GRP_CTRL) begin
            case (c.addr)
                16'd0:   m_stop_conds = agc_sig_pkg::stop_conds_t'(c.data[2:0]);
                16'd1:   m_inhibits = agc_sig_pkg::inhibits_t'(c.data[6:0]);
                16'd3:   m_stop_cause = '0;
                default: ;
            endcase
        end else if (c.group == monitor_cmd_pkg::GRP_STATUS && c.addr == 16'd0) begin
            m_latched = m_latched & ~c.data[10:0];
        end
    endfunction

    `include "monitor_tb_checks.svh"

    task automatic hold_alarms(agc_sig_pkg::alarms_t a, int cycles);
        alarms = a;
        m_latched = m_latched | ~a;
        step_cycles(cycles);
        alarms = '1;
        // Let the release pass through the synchronizer
        step_cycles(ALARM_SYNC_STAGES + 2);
    endtask

    // Index 2 is mpal_n low, 1 is mgojam, 0 is mnisq
    task automatic drive_stop_event(int idx);
        agc_sig_pkg::alarms_t a;
        a = '1;
        case (idx)
            2: begin
                a.mpal_n = 1'b0;
                m_latched = m_latched | ~a;
                alarms = a;
            end
            1:       mgojam = 1'b1;
            default: mnisq = 1'b1;
        endcase
        step_cycles(1);
        alarms = '1;
        mgojam = 1'b0;
        mnisq = 1'b0;
        step_cycles(ALARM_SYNC_STAGES + 2);
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // Read messages are compared mid-cycle
    always @(negedge clk) begin
        if (rst_n && read_msg_valid) begin
            if (exp_q.size() == 0) begin
                err_count++;
                $display("Read message arrived with none expected");
            end else begin
                check_msg(read_msg, exp_q.pop_front());
            end
        end
    end

    // Length of each mstrt pulse
    always @(negedge clk) begin
        if (mstrt) begin
            mstrt_run++;
        end else if (mstrt_run != 0) begin
            mstrt_width = mstrt_run;
            mstrt_pulses++;
            mstrt_run = 0;
        end
    end

    initial begin
        logic [31:0] r;
        logic [15:0] d;
        int          pulses_before;

        void'($urandom(67406));
        clk = 1'b0;
        rst_n = 1'b0;
        cmd_valid = 1'b0;
        cmd = '0;
        monwt = 1'b0;
        mwl = '0;
        gates = '0;
        mgojam = 1'b0;
        mnisq = 1'b0;
        alarms = '1;
        m_stop_conds = '0;
        m_stop_cause = '0;
        m_inhibits = '0;
        m_latched = '0;
        for (int i = 0; i < 6; i++) begin
            m_regs[i] = '0;
        end
        err_count = 0;
        check_count = 0;
        cycle_count = 0;
        mstrt_run = 0;
        mstrt_width = 0;
        mstrt_pulses = 0;
        step_cycles(2);
        rst_n = 1'b1;
        step_cycles(1);

        // Control register readback and inhibit outputs
        for (int n = 0; n < 8; n++) begin
            r = $urandom;
            write_reg(monitor_cmd_pkg::GRP_CTRL, 16'd1, r[15:0]);
            check_inhibits(inhibits, agc_sig_pkg::inhibits_t'(r[6:0]));
            read_reg(monitor_cmd_pkg::GRP_CTRL, 16'd1);
            write_reg(monitor_cmd_pkg::GRP_CTRL, 16'd0, r[31:16]);
            read_reg(monitor_cmd_pkg::GRP_CTRL, 16'd0);
        end
        read_reg(7'h10, 16'd0);
        read_reg(monitor_cmd_pkg::GRP_CTRL, 16'd9);
        read_reg(monitor_cmd_pkg::GRP_MON_REG, 16'd7);

        // Start pulse
        pulses_before = mstrt_pulses;
        write_reg(monitor_cmd_pkg::GRP_CTRL, 16'd2, 16'h0000);
        while (mstrt) step_cycles(1);
        @(negedge clk);
        #1;
        check_width("mstrt width", mstrt_width, START_PULSE_CYCLES);
        check_width("mstrt pulse count", mstrt_pulses - pulses_before, 1);
        step_cycles(1);

        // Stop conditions, enabled and then masked
        for (int i = 0; i < 3; i++) begin
            d = 16'd1 << i;
            write_reg(monitor_cmd_pkg::GRP_CTRL, 16'd0, d);
            drive_stop_event(i);
            m_stop_cause = agc_sig_pkg::stop_conds_t'(d[2:0]);
            check_level("mstp", mstp, 1'b1);
            read_reg(monitor_cmd_pkg::GRP_CTRL, 16'd4);
            write_reg(monitor_cmd_pkg::GRP_CTRL, 16'd3, 16'h0000);
            check_level("mstp", mstp, 1'b0);
            read_reg(monitor_cmd_pkg::GRP_CTRL, 16'd4);
            write_reg(monitor_cmd_pkg::GRP_CTRL, 16'd0, 16'h0007 & ~d);
            drive_stop_event(i);
            check_level("mstp", mstp, 1'b0);
            read_reg(monitor_cmd_pkg::GRP_CTRL, 16'd4);
        end
        write_reg(monitor_cmd_pkg::GRP_CTRL, 16'd0, 16'h0000);

        // Sticky alarms and write-one-to-clear
        for (int n = 0; n < 4; n++) begin
            r = $urandom;
            hold_alarms(agc_sig_pkg::alarms_t'(r[10:0]), 5);
            read_reg(monitor_cmd_pkg::GRP_STATUS, 16'd0);
            read_reg(monitor_cmd_pkg::GRP_STATUS, 16'd1);
            write_reg(monitor_cmd_pkg::GRP_STATUS, 16'd0, {5'b0, r[26:16]});
            read_reg(monitor_cmd_pkg::GRP_STATUS, 16'd0);
        end

        // Central register capture on monwt
        for (int n = 0; n < 10; n++) begin
            r = $urandom;
            mwl = r[15:0];
            gates = agc_sig_pkg::write_gates_t'(r[21:16]);
            monwt = 1'b1;
            for (int i = 0; i < 6; i++) begin
                if (r[21 - i]) begin
                    m_regs[i] = r[15:0];
                end
            end
            step_cycles(1);
            // Only the rising edge of monwt captures
            mwl = ~r[15:0];
            step_cycles(1);
            monwt = 1'b0;
            step_cycles(1);
            for (int a = 0; a < 6; a++) begin
                read_reg(monitor_cmd_pkg::GRP_MON_REG, 16'(a));
            end
        end

        step_cycles(4);
        if (exp_q.size() != 0) begin
            err_count++;
            $display("%0d expected read messages never arrived", exp_q.size());
        end
        $display("Checks: %0d  errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+bench
hw/monitor_cmd_pkg.sv
hw/agc_sig_pkg.sv
hw/cmd_controller.sv
hw/control_regs.sv
hw/start_stop.sv
hw/status_regs.sv
hw/monitor_regs.sv
hw/monitor.sv
bench/monitor_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module monitor_tb -o monitor_sim

out=$(./obj_dir/monitor_sim)
echo "$out"

if echo "$out" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1
